// ==== source/opn_pkg.sv ====
/*
 * Shared types and constants for the FM chip register front end and timers.
 * Only the timer registers 0x24..0x27 of the first bank are decoded.
 * Any other register number maps to REG_NONE and is dropped.
 */
`default_nettype none

package opn_pkg;

    localparam int DATA_W = 8;   // CPU bus width
    localparam int TA_W   = 10;  // Timer A counter width
    localparam int TB_W   = 8;   // Timer B counter width

    // Status byte layout, other bits read as zero
    localparam int STATUS_BUSY_BIT   = 7;
    localparam int STATUS_FLAG_B_BIT = 1;
    localparam int STATUS_FLAG_A_BIT = 0;

    // Register 0x27 bit positions
    localparam int TCTL_LOAD_A = 0;
    localparam int TCTL_LOAD_B = 1;
    localparam int TCTL_EN_A   = 2;
    localparam int TCTL_EN_B   = 3;
    localparam int TCTL_CLR_A  = 4;
    localparam int TCTL_CLR_B  = 5;

    // Target of a queued register write
    typedef enum logic [2:0] {
        REG_NONE  = 3'd0,  // Unmapped, ignored downstream
        REG_TA_HI = 3'd1,  // 0x24, timer A bits 9..2
        REG_TA_LO = 3'd2,  // 0x25, timer A bits 1..0
        REG_TB    = 3'd3,  // 0x26
        REG_TCTL  = 3'd4   // 0x27, load/enable/clear
    } reg_sel_e;

    // Bus decoder state
    typedef enum logic {
        ADDR_WAIT = 1'b0,  // No register number latched yet
        ADDR_HELD = 1'b1
    } bus_phase_e;

endpackage

`default_nettype wire

// ==== source/opn_bus_decode.sv ====
/*
 * CPU bus decoder. A write is cs_n and wr_n both low on a clock edge.
 * addr[0] low latches the register number, high pushes a data write.
 * addr[1] selects the second bank on the full chip and is ignored here.
 */
`default_nettype none

module opn_bus_decode import opn_pkg::*; (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              cs_n,
    input  logic              wr_n,
    input  logic [1:0]        addr,
    input  logic [DATA_W-1:0] din,
    output logic              push,
    output reg_sel_e          push_sel,
    output logic [DATA_W-1:0] push_data
);

    bus_phase_e        phase;
    logic [DATA_W-1:0] reg_num;   // Last register number written
    logic              write;

    assign write     = !cs_n && !wr_n;
    assign push      = write && addr[0];
    assign push_data = din;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            phase <= ADDR_WAIT;
        end else if (write && !addr[0]) begin
            phase <= ADDR_HELD;
        end
    end

    // Register number stays latched across data writes, as on the real chip
    always_ff @(posedge clk) begin
        if (write && !addr[0]) reg_num <= din;
    end

    always_comb begin
        push_sel = REG_NONE;  // Data write before any address write
        if (phase == ADDR_HELD) begin
            case (reg_num)
                DATA_W'('h24): push_sel = REG_TA_HI;
                DATA_W'('h25): push_sel = REG_TA_LO;
                DATA_W'('h26): push_sel = REG_TB;
                DATA_W'('h27): push_sel = REG_TCTL;
                default:       push_sel = REG_NONE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== source/opn_write_queue.sv ====
/*
 * Circular write queue between the CPU bus and the register apply logic.
 * A push while full is dropped, so the CPU must poll busy first.
 * Head outputs are only meaningful while not_empty is high.
 */
`default_nettype none

module opn_write_queue import opn_pkg::*; #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              push,
    input  reg_sel_e          push_sel,
    input  logic [DATA_W-1:0] push_data,
    input  logic              pop,
    output reg_sel_e          head_sel,
    output logic [DATA_W-1:0] head_data,
    output logic              not_empty
);

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    reg_sel_e          sel_mem  [QUEUE_DEPTH];
    logic [DATA_W-1:0] data_mem [QUEUE_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic              full;
    logic              do_push;
    logic              do_pop;

    // Wraps for any depth, not only powers of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full      = (count == CNT_W'(QUEUE_DEPTH));
    assign not_empty = (count != '0);
    assign do_push   = push && !full;
    assign do_pop    = pop && not_empty;
    assign head_sel  = sel_mem[rd_ptr];
    assign head_data = data_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            sel_mem[wr_ptr]  <= push_sel;
            data_mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= next_ptr(wr_ptr);
            if (do_pop)  rd_ptr <= next_ptr(rd_ptr);
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Idle or simultaneous push/pop
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== source/opn_reg_apply.sv ====
/*
 * Internal clock enable, sample tick and timer register file.
 * clk_en fires once every PRESCALE cen cycles, sample_tick every SLOTS clk_en.
 * One queued write is applied per clk_en. Clear bits of 0x27 are one-cycle
 * pulses, load and enable bits are held levels.
 */
`default_nettype none

module opn_reg_apply import opn_pkg::*; #(
    parameter int PRESCALE = 6,
    parameter int SLOTS    = 24
) (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              cen,
    input  logic              not_empty,
    input  reg_sel_e          head_sel,
    input  logic [DATA_W-1:0] head_data,
    output logic              pop,
    output logic              sample_tick,
    output logic [TA_W-1:0]   value_a,
    output logic [TB_W-1:0]   value_b,
    output logic              load_a,
    output logic              load_b,
    output logic              en_a,
    output logic              en_b,
    output logic              clr_a,
    output logic              clr_b
);

    localparam int PRE_W  = (PRESCALE > 1) ? $clog2(PRESCALE) : 1;
    localparam int SLOT_W = (SLOTS > 1) ? $clog2(SLOTS) : 1;

    logic [PRE_W-1:0]  pre_cnt;
    logic [SLOT_W-1:0] slot_cnt;
    logic              clk_en;   // Internal tick

    assign clk_en      = cen && (pre_cnt == PRE_W'(PRESCALE - 1));
    assign sample_tick = clk_en && (slot_cnt == SLOT_W'(SLOTS - 1));
    assign pop         = clk_en && not_empty;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pre_cnt  <= '0;
            slot_cnt <= '0;
        end else begin
            if (cen)    pre_cnt  <= clk_en ? '0 : pre_cnt + 1'b1;
            if (clk_en) slot_cnt <= sample_tick ? '0 : slot_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            value_a <= '0;
            value_b <= '0;
            load_a  <= 1'b0;
            load_b  <= 1'b0;
            en_a    <= 1'b0;
            en_b    <= 1'b0;
            clr_a   <= 1'b0;
            clr_b   <= 1'b0;
        end else begin
            clr_a <= 1'b0;  // Pulses last one cycle
            clr_b <= 1'b0;
            if (pop) begin
                case (head_sel)
                    REG_TA_HI: value_a[TA_W-1:2] <= head_data[TA_W-3:0];
                    REG_TA_LO: value_a[1:0]      <= head_data[1:0];
                    REG_TB:    value_b           <= head_data[TB_W-1:0];
                    REG_TCTL: begin
                        load_a <= head_data[TCTL_LOAD_A];
                        load_b <= head_data[TCTL_LOAD_B];
                        en_a   <= head_data[TCTL_EN_A];
                        en_b   <= head_data[TCTL_EN_B];
                        clr_a  <= head_data[TCTL_CLR_A];
                        clr_b  <= head_data[TCTL_CLR_B];
                    end
                    default: ;  // REG_NONE, write discarded
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/opn_timers.sv ====
/*
 * Timer A and timer B up-counters with sticky overflow flags.
 * A counter runs only while its load bit is set and restarts from its value
 * on the rising edge of load. Timer B steps every TB_DIV sample ticks, and
 * its divider restarts on load so the first period is full length.
 */
`default_nettype none

module opn_timers import opn_pkg::*; #(
    parameter int TB_DIV = 16
) (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            sample_tick,
    input  logic [TA_W-1:0] value_a,
    input  logic [TB_W-1:0] value_b,
    input  logic            load_a,
    input  logic            load_b,
    input  logic            en_a,
    input  logic            en_b,
    input  logic            clr_a,
    input  logic            clr_b,
    output logic            flag_a,
    output logic            flag_b
);

    localparam int DIV_W = (TB_DIV > 1) ? $clog2(TB_DIV) : 1;

    logic [TA_W-1:0]  cnt_a;
    logic [TB_W-1:0]  cnt_b;
    logic [DIV_W-1:0] div_cnt;
    logic             load_a_d;
    logic             load_b_d;
    logic             start_a;
    logic             start_b;
    logic             step_b;
    logic             ovf_a;
    logic             ovf_b;

    assign start_a = load_a && !load_a_d;
    assign start_b = load_b && !load_b_d;
    assign step_b  = sample_tick && (div_cnt == DIV_W'(TB_DIV - 1));

    // Overflow on the step taken while the counter sits at all ones
    assign ovf_a = load_a && !start_a && sample_tick && (cnt_a == '1);
    assign ovf_b = load_b && !start_b && step_b && (cnt_b == '1);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            load_a_d <= 1'b0;
            cnt_a    <= '0;
        end else begin
            load_a_d <= load_a;
            if (start_a) begin
                cnt_a <= value_a;
            end else if (load_a && sample_tick) begin
                cnt_a <= ovf_a ? value_a : cnt_a + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            load_b_d <= 1'b0;
            div_cnt  <= '0;
            cnt_b    <= '0;
        end else begin
            load_b_d <= load_b;
            if (start_b) begin
                div_cnt <= '0;
                cnt_b   <= value_b;
            end else begin
                if (sample_tick) div_cnt <= step_b ? '0 : div_cnt + 1'b1;
                if (load_b && step_b) cnt_b <= ovf_b ? value_b : cnt_b + 1'b1;
            end
        end
    end

    // An overflow in the same cycle as a clear wins
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            flag_a <= 1'b0;
            flag_b <= 1'b0;
        end else begin
            if (ovf_a && en_a) flag_a <= 1'b1;
            else if (clr_a)    flag_a <= 1'b0;
            if (ovf_b && en_b) flag_b <= 1'b1;
            else if (clr_b)    flag_b <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== source/opn_timer_top.sv ====
/*
 * Register front end and timers of the FM sound chip.
 * dout always returns the status byte, one cycle behind busy and the flags.
 * Poll busy before each data write, a write into a full queue is lost.
 */
`default_nettype none

module opn_timer_top import opn_pkg::*; #(
    parameter int PRESCALE    = 6,
    parameter int SLOTS       = 24,
    parameter int TB_DIV      = 16,
    parameter int QUEUE_DEPTH = 4
) (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              cen,     // Tie high if not needed
    input  logic              cs_n,
    input  logic              wr_n,
    input  logic [1:0]        addr,
    input  logic [DATA_W-1:0] din,
    output logic [DATA_W-1:0] dout,
    output logic              irq_n
);

    logic              push;
    reg_sel_e          push_sel;
    logic [DATA_W-1:0] push_data;
    logic              pop;
    reg_sel_e          head_sel;
    logic [DATA_W-1:0] head_data;
    logic              busy;          // Queue not empty
    logic              sample_tick;
    logic [TA_W-1:0]   value_a;
    logic [TB_W-1:0]   value_b;
    logic              load_a, load_b;
    logic              en_a, en_b;
    logic              clr_a, clr_b;
    logic              flag_a, flag_b;
    logic [DATA_W-1:0] status_next;

    opn_bus_decode u_decode (
        .clk       ( clk       ),
        .arst_n    ( arst_n    ),
        .cs_n      ( cs_n      ),
        .wr_n      ( wr_n      ),
        .addr      ( addr      ),
        .din       ( din       ),
        .push      ( push      ),
        .push_sel  ( push_sel  ),
        .push_data ( push_data )
    );

    opn_write_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_queue (
        .clk       ( clk       ),
        .arst_n    ( arst_n    ),
        .push      ( push      ),
        .push_sel  ( push_sel  ),
        .push_data ( push_data ),
        .pop       ( pop       ),
        .head_sel  ( head_sel  ),
        .head_data ( head_data ),
        .not_empty ( busy      )
    );

    opn_reg_apply #(.PRESCALE(PRESCALE), .SLOTS(SLOTS)) u_apply (
        .clk         ( clk         ),
        .arst_n      ( arst_n      ),
        .cen         ( cen         ),
        .not_empty   ( busy        ),
        .head_sel    ( head_sel    ),
        .head_data   ( head_data   ),
        .pop         ( pop         ),
        .sample_tick ( sample_tick ),
        .value_a     ( value_a     ),
        .value_b     ( value_b     ),
        .load_a      ( load_a      ),
        .load_b      ( load_b      ),
        .en_a        ( en_a        ),
        .en_b        ( en_b        ),
        .clr_a       ( clr_a       ),
        .clr_b       ( clr_b       )
    );

    opn_timers #(.TB_DIV(TB_DIV)) u_timers (
        .clk         ( clk         ),
        .arst_n      ( arst_n      ),
        .sample_tick ( sample_tick ),
        .value_a     ( value_a     ),
        .value_b     ( value_b     ),
        .load_a      ( load_a      ),
        .load_b      ( load_b      ),
        .en_a        ( en_a        ),
        .en_b        ( en_b        ),
        .clr_a       ( clr_a       ),
        .clr_b       ( clr_b       ),
        .flag_a      ( flag_a      ),
        .flag_b      ( flag_b      )
    );

    assign irq_n = !(flag_a || flag_b);

    always_comb begin
        status_next                    = '0;
        status_next[STATUS_BUSY_BIT]   = busy;
        status_next[STATUS_FLAG_B_BIT] = flag_b;
        status_next[STATUS_FLAG_A_BIT] = flag_a;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) dout <= '0;
        else         dout <= status_next;
    end

endmodule

`default_nettype wire

// ==== test/tb_clock.sv ====
/*
 * Free running clock for the testbench and an active low reset.
 * Reset is released on a falling edge after RESET_CYCLES rising edges.
 */
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic arst_n
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);  // Release away from the active edge
        arst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== test/opn_timer_tb.sv ====
/*
 * Testbench for the timer front end, default parameters, cen tied high.
 * Timer values are random but kept away from the shortest periods, so the
 * 90% and 110% windows stay wider than the unknown phase of the first tick.
 * Register mapping is observed on the decoder's push_sel inside the DUT.
 */
`default_nettype none

module opn_timer_tb import opn_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int PRESCALE    = 6;
    localparam int SLOTS       = 24;
    localparam int TB_DIV      = 16;
    localparam int QUEUE_DEPTH = 4;
    localparam int CLK_NS      = 20;

    localparam longint TICK_CLKS  = PRESCALE * SLOTS;  // Clocks per sample tick
    localparam longint A_MAX_CLKS = 1024 * TICK_CLKS;
    localparam longint B_MAX_CLKS = 256 * TB_DIV * TICK_CLKS;
    // Timer A runs about four periods in all, timer B one
    localparam longint LIMIT_NS   = (5 * A_MAX_CLKS + 2 * B_MAX_CLKS + 20000) * CLK_NS;
    localparam int     DRAIN_CLKS = QUEUE_DEPTH * PRESCALE + 4;

    logic              clk;
    logic              arst_n;
    logic              cen;
    logic              cs_n;
    logic              wr_n;
    logic [1:0]        addr;
    logic [DATA_W-1:0] din;
    logic [DATA_W-1:0] dout;
    logic              irq_n;
    int unsigned       seed_init;

    tb_clock #(.PERIOD_NS(CLK_NS), .RESET_CYCLES(4)) clock_gen (
        .clk    ( clk    ),
        .arst_n ( arst_n )
    );

    opn_timer_top #(
        .PRESCALE    ( PRESCALE    ),
        .SLOTS       ( SLOTS       ),
        .TB_DIV      ( TB_DIV      ),
        .QUEUE_DEPTH ( QUEUE_DEPTH )
    ) UUT (
        .clk    ( clk    ),
        .arst_n ( arst_n ),
        .cen    ( cen    ),
        .cs_n   ( cs_n   ),
        .wr_n   ( wr_n   ),
        .addr   ( addr   ),
        .din    ( din    ),
        .dout   ( dout   ),
        .irq_n  ( irq_n  )
    );

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("Done: errors found");
        $fatal(1, "Run stopped at first error");
    endtask

    task automatic check_status(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp);
        if (got !== exp)
            stop_on_error($sformatf("** Error: dout = 0x%02h, expected 0x%02h", got, exp));
    endtask

    task automatic check_irq(input logic got, input logic exp);
        if (got !== exp)
            stop_on_error($sformatf("** Error: irq_n = 0x%0h, expected 0x%0h", got, exp));
    endtask

    task automatic check_sel(input reg_sel_e got, input reg_sel_e exp);
        if (got !== exp)
            stop_on_error($sformatf("** Error: push_sel = 0x%0h, expected 0x%0h", got, exp));
    endtask

    // Status byte as the CPU should see it
    function automatic logic [DATA_W-1:0] status_byte(input logic busy, input logic fb,
                                                      input logic fa);
        logic [DATA_W-1:0] s;
        s                    = '0;
        s[STATUS_BUSY_BIT]   = busy;
        s[STATUS_FLAG_B_BIT] = fb;
        s[STATUS_FLAG_A_BIT] = fa;
        return s;
    endfunction

    function automatic reg_sel_e expected_sel(input logic [DATA_W-1:0] num);
        case (num)
            8'h24:   return REG_TA_HI;
            8'h25:   return REG_TA_LO;
            8'h26:   return REG_TB;
            8'h27:   return REG_TCTL;
            default: return REG_NONE;
        endcase
    endfunction

    function automatic longint period_a(input int unsigned value);
        return longint'(1024 - value) * TICK_CLKS;
    endfunction

    function automatic longint period_b(input int unsigned value);
        return longint'(256 - value) * TB_DIV * TICK_CLKS;
    endfunction

    // One bus write strobe, entered and left on a falling edge
    task automatic bus_write(input logic a0, input logic [DATA_W-1:0] data);
        cs_n = 1'b0;
        wr_n = 1'b0;
        addr = {1'($urandom % 2), a0};  // Bank bit should not matter
        din  = data;
        @(negedge clk);
        cs_n = 1'b1;
        wr_n = 1'b1;
    endtask

    // Status lags busy by a cycle, so skip one edge before polling
    task automatic wait_idle();
        int n;
        n = 0;
        @(negedge clk);
        while (dout[STATUS_BUSY_BIT] !== 1'b0) begin
            if (n >= DRAIN_CLKS) begin
                stop_on_error("Busy stayed high longer than the write queue takes to drain");
            end else begin
                n++;
                @(negedge clk);
            end
        end
    endtask

    task automatic write_reg(input logic [DATA_W-1:0] num, input logic [DATA_W-1:0] data);
        bus_write(1'b0, num);
        wait_idle();
        bus_write(1'b1, data);
    endtask

    // Flag clear at 90% of the period, set at 110%
    task automatic check_period(input longint period, input logic [DATA_W-1:0] flag_status);
        longint early;
        longint late;
        early = period * 9 / 10;
        late  = period * 11 / 10;
        repeat (early) @(negedge clk);
        check_status(dout, status_byte(1'b0, 1'b0, 1'b0));
        check_irq(irq_n, 1'b1);
        repeat (late - early) @(negedge clk);
        check_status(dout, flag_status);
        check_irq(irq_n, 1'b0);
    endtask

    initial begin
        #(LIMIT_NS);
        stop_on_error("Timeout: the tests did not finish within the expected time");
    end

    initial begin
        logic [DATA_W-1:0] num;
        int unsigned       val_a;
        int unsigned       val_b;
        seed_init = $urandom(32'he9cb99b8);
        cen  = 1'b1;
        cs_n = 1'b1;
        wr_n = 1'b1;
        addr = '0;
        din  = '0;
        wait (arst_n === 1'b1);
        @(negedge clk);

        // Reset state
        check_status(dout, status_byte(1'b0, 1'b0, 1'b0));
        check_irq(irq_n, 1'b1);
        check_sel(UUT.u_decode.push_sel, REG_NONE);  // No address latched yet

        for (int i = 0; i < 6; i++) begin
            num = (i < 4) ? 8'(8'h24 + i) : (i == 4) ? 8'h30 : 8'($urandom);
            bus_write(1'b0, num);
            check_sel(UUT.u_decode.push_sel, expected_sel(num));
        end

        // Busy after one data write
        bus_write(1'b0, 8'h26);
        wait_idle();
        bus_write(1'b1, 8'($urandom));
        @(negedge clk);
        check_status(dout, status_byte(1'b1, 1'b0, 1'b0));
        wait_idle();
        check_status(dout, status_byte(1'b0, 1'b0, 1'b0));

        // Timer A with a random value
        val_a = $urandom % 1000;
        write_reg(8'h24, 8'(val_a >> 2));
        write_reg(8'h25, 8'(val_a & 3));
        write_reg(8'h27, 8'((1 << TCTL_LOAD_A) | (1 << TCTL_EN_A)));
        wait_idle();
        check_period(period_a(val_a), status_byte(1'b0, 1'b0, 1'b1));

        write_reg(8'h27, 8'(1 << TCTL_CLR_A));
        wait_idle();
        @(negedge clk);  // Clear lands after the apply, status a cycle later
        check_status(dout, status_byte(1'b0, 1'b0, 1'b0));
        check_irq(irq_n, 1'b1);

        // Running but not enabled
        write_reg(8'h27, 8'(1 << TCTL_LOAD_A));
        wait_idle();
        repeat (2 * period_a(val_a)) @(negedge clk);
        check_status(dout, status_byte(1'b0, 1'b0, 1'b0));
        check_irq(irq_n, 1'b1);

        // Timer B, only status bit 1 may move
        val_b = $urandom % 250;
        write_reg(8'h26, 8'(val_b));
        write_reg(8'h27, 8'((1 << TCTL_LOAD_B) | (1 << TCTL_EN_B)));
        wait_idle();
        check_period(period_b(val_b), status_byte(1'b0, 1'b1, 1'b0));

        write_reg(8'h27, 8'(1 << TCTL_CLR_B));
        wait_idle();
        @(negedge clk);
        check_status(dout, status_byte(1'b0, 1'b0, 1'b0));
        check_irq(irq_n, 1'b1);

        // Would load and enable both timers if it reached 0x27
        write_reg(8'h30, 8'h0F);
        wait_idle();
        repeat (period_a(val_a) * 11 / 10) @(negedge clk);
        check_status(dout, status_byte(1'b0, 1'b0, 1'b0));
        check_irq(irq_n, 1'b1);

        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
source/opn_pkg.sv
source/opn_bus_decode.sv
source/opn_write_queue.sv
source/opn_reg_apply.sv
source/opn_timers.sv
source/opn_timer_top.sv
test/tb_clock.sv
test/opn_timer_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = opn_timer_tb
FILELIST  = project.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = Done: no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: compile
	-./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "Simulation passed" || \
		(echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
